/* verilog.f */
ip_proto_pkg.sv
frame_pkg.sv
ip_proto_demux.sv
udp_hdr_rx.sv
udp_hdr_tx.sv
ip_frame_arb.sv
udp_ip_switch.sv
tb_udp_ip_switch.sv

/* tb_udp_ip_switch.sv */
// Testbench for the UDP/IP switch, table-driven frames checked against a reference model
`timescale 1ns/1ps

module tb_udp_switch import ip_proto_pkg::*, frame_pkg::*; ();

    // dir: 0 receive, 1 UDP transmit, 2 IP transmit, 3 UDP and IP transmit together
    typedef struct packed {
        logic [1:0] dir;
        proto_t     proto;
        logic [7:0] len;
    } entry_t;

    localparam int N_ENTRIES = 10;

    logic clk;
    logic rst;
    ip_hdr_t s_ip_rx_hdr, m_ip_rx_hdr, s_ip_tx_hdr, m_ip_tx_hdr;
    udp_hdr_t m_udp_rx_hdr, s_udp_tx_hdr;
    stream_beat_t s_ip_rx_beat, m_ip_rx_beat, m_udp_rx_beat;
    stream_beat_t s_udp_tx_beat, s_ip_tx_beat, m_ip_tx_beat;
    logic s_ip_rx_hdr_valid, s_ip_rx_hdr_ready, s_ip_rx_beat_valid, s_ip_rx_beat_ready;
    logic m_ip_rx_hdr_valid, m_ip_rx_hdr_ready, m_ip_rx_beat_valid, m_ip_rx_beat_ready;
    logic m_udp_rx_hdr_valid, m_udp_rx_hdr_ready, m_udp_rx_beat_valid, m_udp_rx_beat_ready;
    logic s_udp_tx_hdr_valid, s_udp_tx_hdr_ready, s_udp_tx_beat_valid, s_udp_tx_beat_ready;
    logic s_ip_tx_hdr_valid, s_ip_tx_hdr_ready, s_ip_tx_beat_valid, s_ip_tx_beat_ready;
    logic m_ip_tx_hdr_valid, m_ip_tx_hdr_ready, m_ip_tx_beat_valid, m_ip_tx_beat_ready;
    logic udp_rx_error_hdr_early;

    entry_t   tbl [0:N_ENTRIES-1];
    byte_t    rx_pay [0:255];
    byte_t    utx_pay [0:255];
    byte_t    itx_pay [0:255];
    ip_hdr_t  exp_iprx_hdr [$];
    udp_hdr_t exp_udprx_hdr [$];
    ip_hdr_t  exp_tx_hdr [$];
    logic [8:0] exp_iprx_beat [$];
    logic [8:0] exp_udprx_beat [$];
    logic [8:0] exp_tx_beat [$];
    integer seed = 32'h6ff239e1;
    int     errors = 0;
    int     exp_err = 0;
    int     err_pulses = 0;
    int     limit;
    int     j;
    int     k;
    logic   hold_tx = 1'b0;

    udp_switch dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task check(input string name, input logic [143:0] exp, input logic [143:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Build expected results for one received frame, then drive it
    task run_rx(input entry_t e);
        ip_hdr_t  h;
        udp_hdr_t u;
        int i;
        h = 104'({$random(seed), $random(seed), $random(seed), $random(seed)});
        h.protocol = e.proto;
        h.length = 16'(e.len) + 16'd20;
        for (i = 0; i < e.len; i++) rx_pay[i] = $random(seed);
        if (e.proto != 8'd17) begin
            exp_iprx_hdr.push_back(h);
            for (i = 0; i < e.len; i++) exp_iprx_beat.push_back({i == e.len - 1, rx_pay[i]});
        end else if (e.len <= 8) begin
            exp_err++;
        end else begin
            u.dscp = h.dscp;
            u.ecn = h.ecn;
            u.ttl = h.ttl;
            u.source_ip = h.source_ip;
            u.dest_ip = h.dest_ip;
            u.source_port = {rx_pay[0], rx_pay[1]};
            u.dest_port = {rx_pay[2], rx_pay[3]};
            u.length = {rx_pay[4], rx_pay[5]};
            u.checksum = {rx_pay[6], rx_pay[7]};
            exp_udprx_hdr.push_back(u);
            for (i = 8; i < e.len; i++) exp_udprx_beat.push_back({i == e.len - 1, rx_pay[i]});
        end
        @(posedge clk);
        s_ip_rx_hdr <= h;
        s_ip_rx_hdr_valid <= 1'b1;
        do @(posedge clk); while (!s_ip_rx_hdr_ready);
        s_ip_rx_hdr_valid <= 1'b0;
        for (i = 0; i < e.len; i++) begin
            s_ip_rx_beat <= {rx_pay[i], i == e.len - 1, 1'b0};
            s_ip_rx_beat_valid <= 1'b1;
            do @(posedge clk); while (!s_ip_rx_beat_ready);
        end
        s_ip_rx_beat_valid <= 1'b0;
    endtask

    task prep_udp_tx(input int n);
        udp_hdr_t    u;
        ip_hdr_t     h;
        logic [63:0] hdr_bytes;
        int i;
        u = 144'({$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)});
        u.length = 16'(n) + 16'd8;
        h.dscp = u.dscp;
        h.ecn = u.ecn;
        h.length = u.length + 16'd20;
        h.ttl = u.ttl;
        h.protocol = 8'd17;
        h.source_ip = u.source_ip;
        h.dest_ip = u.dest_ip;
        exp_tx_hdr.push_back(h);
        // UDP header on the wire, most significant byte first
        hdr_bytes = {u.source_port, u.dest_port, u.length, u.checksum};
        for (i = 0; i < 8; i++) begin
            exp_tx_beat.push_back({1'b0, hdr_bytes[63:56]});
            hdr_bytes = hdr_bytes << 8;
        end
        for (i = 0; i < n; i++) begin
            utx_pay[i] = $random(seed);
            exp_tx_beat.push_back({i == n - 1, utx_pay[i]});
        end
        s_udp_tx_hdr <= u;
    endtask

    task drive_udp_tx(input int n);
        int i;
        s_udp_tx_hdr_valid <= 1'b1;
        do @(posedge clk); while (!s_udp_tx_hdr_ready);
        s_udp_tx_hdr_valid <= 1'b0;
        for (i = 0; i < n; i++) begin
            s_udp_tx_beat <= {utx_pay[i], i == n - 1, 1'b0};
            s_udp_tx_beat_valid <= 1'b1;
            do @(posedge clk); while (!s_udp_tx_beat_ready);
        end
        s_udp_tx_beat_valid <= 1'b0;
    endtask

    task prep_ip_tx(input proto_t p, input int n);
        ip_hdr_t h;
        int i;
        h = 104'({$random(seed), $random(seed), $random(seed), $random(seed)});
        h.protocol = p;
        h.length = 16'(n) + 16'd20;
        exp_tx_hdr.push_back(h);
        for (i = 0; i < n; i++) begin
            itx_pay[i] = $random(seed);
            exp_tx_beat.push_back({i == n - 1, itx_pay[i]});
        end
        s_ip_tx_hdr <= h;
    endtask

    task drive_ip_tx(input int n);
        int i;
        s_ip_tx_hdr_valid <= 1'b1;
        do @(posedge clk); while (!s_ip_tx_hdr_ready);
        s_ip_tx_hdr_valid <= 1'b0;
        for (i = 0; i < n; i++) begin
            s_ip_tx_beat <= {itx_pay[i], i == n - 1, 1'b0};
            s_ip_tx_beat_valid <= 1'b1;
            do @(posedge clk); while (!s_ip_tx_beat_ready);
        end
        s_ip_tx_beat_valid <= 1'b0;
    endtask

    // Random back-pressure on all outputs
    always @(posedge clk) begin
        m_ip_rx_hdr_ready <= $random(seed);
        m_ip_rx_beat_ready <= $random(seed);
        m_udp_rx_hdr_ready <= $random(seed);
        m_udp_rx_beat_ready <= $random(seed);
        m_ip_tx_hdr_ready <= hold_tx ? 1'b0 : 1'($random(seed));
        m_ip_tx_beat_ready <= $random(seed);
    end

    // Output receivers compare against the reference queues
    always @(posedge clk) begin
        if (!rst) begin
            if (udp_rx_error_hdr_early) err_pulses++;
            if (m_ip_rx_hdr_valid && m_ip_rx_hdr_ready) begin
                if (exp_iprx_hdr.size() == 0) begin
                    errors++;
                    $display("Unexpected header on the IP receive output");
                end else check("ip_rx header", exp_iprx_hdr.pop_front(), m_ip_rx_hdr);
            end
            if (m_ip_rx_beat_valid && m_ip_rx_beat_ready) begin
                if (exp_iprx_beat.size() == 0) begin
                    errors++;
                    $display("Unexpected byte on the IP receive output");
                end else check("ip_rx byte", exp_iprx_beat.pop_front(),
                               {m_ip_rx_beat.last, m_ip_rx_beat.data});
            end
            if (m_udp_rx_hdr_valid && m_udp_rx_hdr_ready) begin
                if (exp_udprx_hdr.size() == 0) begin
                    errors++;
                    $display("Unexpected header on the UDP receive output");
                end else check("udp_rx header", exp_udprx_hdr.pop_front(), m_udp_rx_hdr);
            end
            if (m_udp_rx_beat_valid && m_udp_rx_beat_ready) begin
                if (exp_udprx_beat.size() == 0) begin
                    errors++;
                    $display("Unexpected byte on the UDP receive output");
                end else check("udp_rx byte", exp_udprx_beat.pop_front(),
                               {m_udp_rx_beat.last, m_udp_rx_beat.data});
            end
            if (m_ip_tx_hdr_valid && m_ip_tx_hdr_ready) begin
                if (exp_tx_hdr.size() == 0) begin
                    errors++;
                    $display("Unexpected header on the transmit output");
                end else check("ip_tx header", exp_tx_hdr.pop_front(), m_ip_tx_hdr);
            end
            if (m_ip_tx_beat_valid && m_ip_tx_beat_ready) begin
                if (exp_tx_beat.size() == 0) begin
                    errors++;
                    $display("Unexpected byte on the transmit output");
                end else check("ip_tx byte", exp_tx_beat.pop_front(),
                               {m_ip_tx_beat.last, m_ip_tx_beat.data});
            end
        end
    end

    initial begin
        #1;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst = 1'b1;
        s_ip_rx_hdr = '0;
        s_ip_rx_hdr_valid = 1'b0;
        s_ip_rx_beat = '0;
        s_ip_rx_beat_valid = 1'b0;
        s_udp_tx_hdr = '0;
        s_udp_tx_hdr_valid = 1'b0;
        s_udp_tx_beat = '0;
        s_udp_tx_beat_valid = 1'b0;
        s_ip_tx_hdr = '0;
        s_ip_tx_hdr_valid = 1'b0;
        s_ip_tx_beat = '0;
        s_ip_tx_beat_valid = 1'b0;
        m_ip_rx_hdr_ready = 1'b0;
        m_ip_rx_beat_ready = 1'b0;
        m_udp_rx_hdr_ready = 1'b0;
        m_udp_rx_beat_ready = 1'b0;
        m_ip_tx_hdr_ready = 1'b0;
        m_ip_tx_beat_ready = 1'b0;
        tbl[0] = '{2'd0, 8'd6, 8'd10};
        tbl[1] = '{2'd0, 8'd17, 8'd20};
        tbl[2] = '{2'd0, 8'd17, 8'd5};
        tbl[3] = '{2'd0, 8'd17, 8'd9};
        tbl[4] = '{2'd0, 8'd1, 8'd3};
        tbl[5] = '{2'd1, 8'd17, 8'd6};
        tbl[6] = '{2'd2, 8'd6, 8'd7};
        tbl[7] = '{2'd3, 8'd6, 8'd4};
        tbl[8] = '{2'd1, 8'd17, 8'd1};
        tbl[9] = '{2'd2, 8'd17, 8'd12};
        limit = 0;
        for (j = 0; j < N_ENTRIES; j++) limit += tbl[j].len + 40;
        limit *= 4;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        fork
            begin
                for (j = 0; j < N_ENTRIES; j++) begin
                    if (tbl[j].dir == 2'd0) run_rx(tbl[j]);
                end
            end
            begin
                for (k = 0; k < N_ENTRIES; k++) begin
                    @(posedge clk);
                    case (tbl[k].dir)
                        2'd1: begin
                            prep_udp_tx(tbl[k].len);
                            drive_udp_tx(tbl[k].len);
                        end
                        2'd2: begin
                            prep_ip_tx(tbl[k].proto, tbl[k].len);
                            drive_ip_tx(tbl[k].len);
                        end
                        2'd3: begin
                            // Both headers wait at the arbiter before it may grant
                            hold_tx <= 1'b1;
                            @(posedge clk);
                            prep_udp_tx(tbl[k].len);
                            prep_ip_tx(tbl[k].proto, tbl[k].len);
                            fork
                                drive_udp_tx(tbl[k].len);
                                drive_ip_tx(tbl[k].len);
                                begin
                                    @(posedge clk);
                                    wait (dut0.tx_udp_hdr_valid && s_ip_tx_hdr_valid);
                                    @(posedge clk);
                                    hold_tx <= 1'b0;
                                end
                            join
                        end
                        default: ;
                    endcase
                end
            end
        join
        while (exp_iprx_hdr.size() + exp_iprx_beat.size() + exp_udprx_hdr.size() +
               exp_udprx_beat.size() + exp_tx_hdr.size() + exp_tx_beat.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check("error pulse cycles", exp_err, err_pulses);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* udp_ip_switch.sv */
// UDP/IP switch top, receive demux and parser plus transmit builder and arbiter
`timescale 1ns/1ps

module udp_switch import frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    // Receive side
    input  ip_hdr_t      s_ip_rx_hdr,
    input  logic         s_ip_rx_hdr_valid,
    output logic         s_ip_rx_hdr_ready,
    input  stream_beat_t s_ip_rx_beat,
    input  logic         s_ip_rx_beat_valid,
    output logic         s_ip_rx_beat_ready,
    // Non-UDP frames
    output ip_hdr_t      m_ip_rx_hdr,
    output logic         m_ip_rx_hdr_valid,
    input  logic         m_ip_rx_hdr_ready,
    output stream_beat_t m_ip_rx_beat,
    output logic         m_ip_rx_beat_valid,
    input  logic         m_ip_rx_beat_ready,
    // UDP frames
    output udp_hdr_t     m_udp_rx_hdr,
    output logic         m_udp_rx_hdr_valid,
    input  logic         m_udp_rx_hdr_ready,
    output stream_beat_t m_udp_rx_beat,
    output logic         m_udp_rx_beat_valid,
    input  logic         m_udp_rx_beat_ready,
    // UDP transmit
    input  udp_hdr_t     s_udp_tx_hdr,
    input  logic         s_udp_tx_hdr_valid,
    output logic         s_udp_tx_hdr_ready,
    input  stream_beat_t s_udp_tx_beat,
    input  logic         s_udp_tx_beat_valid,
    output logic         s_udp_tx_beat_ready,
    // External IP transmit
    input  ip_hdr_t      s_ip_tx_hdr,
    input  logic         s_ip_tx_hdr_valid,
    output logic         s_ip_tx_hdr_ready,
    input  stream_beat_t s_ip_tx_beat,
    input  logic         s_ip_tx_beat_valid,
    output logic         s_ip_tx_beat_ready,
    // Merged transmit
    output ip_hdr_t      m_ip_tx_hdr,
    output logic         m_ip_tx_hdr_valid,
    input  logic         m_ip_tx_hdr_ready,
    output stream_beat_t m_ip_tx_beat,
    output logic         m_ip_tx_beat_valid,
    input  logic         m_ip_tx_beat_ready,
    output logic         udp_rx_error_hdr_early
);

    ip_hdr_t      rx_udp_hdr;
    logic         rx_udp_hdr_valid;
    logic         rx_udp_hdr_ready;
    stream_beat_t rx_udp_beat;
    logic         rx_udp_beat_valid;
    logic         rx_udp_beat_ready;

    ip_hdr_t      tx_udp_hdr;
    logic         tx_udp_hdr_valid;
    logic         tx_udp_hdr_ready;
    stream_beat_t tx_udp_beat;
    logic         tx_udp_beat_valid;
    logic         tx_udp_beat_ready;

    ip_proto_demux demux0 (
        .clk            (clk),
        .rst            (rst),
        .in_hdr         (s_ip_rx_hdr),
        .in_hdr_valid   (s_ip_rx_hdr_valid),
        .in_hdr_ready   (s_ip_rx_hdr_ready),
        .in_beat        (s_ip_rx_beat),
        .in_beat_valid  (s_ip_rx_beat_valid),
        .in_beat_ready  (s_ip_rx_beat_ready),
        .udp_hdr        (rx_udp_hdr),
        .udp_hdr_valid  (rx_udp_hdr_valid),
        .udp_hdr_ready  (rx_udp_hdr_ready),
        .udp_beat       (rx_udp_beat),
        .udp_beat_valid (rx_udp_beat_valid),
        .udp_beat_ready (rx_udp_beat_ready),
        .ip_hdr         (m_ip_rx_hdr),
        .ip_hdr_valid   (m_ip_rx_hdr_valid),
        .ip_hdr_ready   (m_ip_rx_hdr_ready),
        .ip_beat        (m_ip_rx_beat),
        .ip_beat_valid  (m_ip_rx_beat_valid),
        .ip_beat_ready  (m_ip_rx_beat_ready)
    );

    udp_hdr_rx rx0 (
        .clk             (clk),
        .rst             (rst),
        .ip_hdr          (rx_udp_hdr),
        .ip_hdr_valid    (rx_udp_hdr_valid),
        .ip_hdr_ready    (rx_udp_hdr_ready),
        .ip_beat         (rx_udp_beat),
        .ip_beat_valid   (rx_udp_beat_valid),
        .ip_beat_ready   (rx_udp_beat_ready),
        .udp_hdr         (m_udp_rx_hdr),
        .udp_hdr_valid   (m_udp_rx_hdr_valid),
        .udp_hdr_ready   (m_udp_rx_hdr_ready),
        .udp_beat        (m_udp_rx_beat),
        .udp_beat_valid  (m_udp_rx_beat_valid),
        .udp_beat_ready  (m_udp_rx_beat_ready),
        .error_hdr_early (udp_rx_error_hdr_early)
    );

    udp_hdr_tx tx0 (
        .clk            (clk),
        .rst            (rst),
        .udp_hdr        (s_udp_tx_hdr),
        .udp_hdr_valid  (s_udp_tx_hdr_valid),
        .udp_hdr_ready  (s_udp_tx_hdr_ready),
        .udp_beat       (s_udp_tx_beat),
        .udp_beat_valid (s_udp_tx_beat_valid),
        .udp_beat_ready (s_udp_tx_beat_ready),
        .ip_hdr         (tx_udp_hdr),
        .ip_hdr_valid   (tx_udp_hdr_valid),
        .ip_hdr_ready   (tx_udp_hdr_ready),
        .ip_beat        (tx_udp_beat),
        .ip_beat_valid  (tx_udp_beat_valid),
        .ip_beat_ready  (tx_udp_beat_ready)
    );

    // UDP path on input 0 has priority
    ip_frame_arb arb0 (
        .clk            (clk),
        .rst            (rst),
        .in0_hdr        (tx_udp_hdr),
        .in0_hdr_valid  (tx_udp_hdr_valid),
        .in0_hdr_ready  (tx_udp_hdr_ready),
        .in0_beat       (tx_udp_beat),
        .in0_beat_valid (tx_udp_beat_valid),
        .in0_beat_ready (tx_udp_beat_ready),
        .in1_hdr        (s_ip_tx_hdr),
        .in1_hdr_valid  (s_ip_tx_hdr_valid),
        .in1_hdr_ready  (s_ip_tx_hdr_ready),
        .in1_beat       (s_ip_tx_beat),
        .in1_beat_valid (s_ip_tx_beat_valid),
        .in1_beat_ready (s_ip_tx_beat_ready),
        .out_hdr        (m_ip_tx_hdr),
        .out_hdr_valid  (m_ip_tx_hdr_valid),
        .out_hdr_ready  (m_ip_tx_hdr_ready),
        .out_beat       (m_ip_tx_beat),
        .out_beat_valid (m_ip_tx_beat_valid),
        .out_beat_ready (m_ip_tx_beat_ready)
    );

endmodule

/* ip_frame_arb.sv */
// Two-input IP frame arbiter, fixed priority to input 0, whole frames only
`timescale 1ns/1ps

module ip_frame_arb import frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  ip_hdr_t      in0_hdr,
    input  logic         in0_hdr_valid,
    output logic         in0_hdr_ready,
    input  stream_beat_t in0_beat,
    input  logic         in0_beat_valid,
    output logic         in0_beat_ready,
    input  ip_hdr_t      in1_hdr,
    input  logic         in1_hdr_valid,
    output logic         in1_hdr_ready,
    input  stream_beat_t in1_beat,
    input  logic         in1_beat_valid,
    output logic         in1_beat_ready,
    output ip_hdr_t      out_hdr,
    output logic         out_hdr_valid,
    input  logic         out_hdr_ready,
    output stream_beat_t out_beat,
    output logic         out_beat_valid,
    input  logic         out_beat_ready
);

    typedef enum logic [1:0] {idle, grant0, grant1} grant_t;

    grant_t state;

    // Input 0 wins whenever it has a header waiting
    assign out_hdr       = in0_hdr_valid ? in0_hdr : in1_hdr;
    assign out_hdr_valid = (state == idle) && (in0_hdr_valid || in1_hdr_valid);
    assign in0_hdr_ready = (state == idle) && out_hdr_ready;
    assign in1_hdr_ready = (state == idle) && !in0_hdr_valid && out_hdr_ready;

    assign out_beat       = (state == grant1) ? in1_beat : in0_beat;
    assign out_beat_valid = ((state == grant0) && in0_beat_valid) ||
                            ((state == grant1) && in1_beat_valid);
    assign in0_beat_ready = (state == grant0) && out_beat_ready;
    assign in1_beat_ready = (state == grant1) && out_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (out_hdr_valid && out_hdr_ready) begin
                        state <= in0_hdr_valid ? grant0 : grant1;
                    end
                end
                default: begin
                    // Hold the grant until the frame's last byte leaves
                    if (out_beat_valid && out_beat_ready && out_beat.last) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

endmodule

/* udp_hdr_tx.sv */
// UDP transmit builder, forms the IP header and prepends the UDP header bytes
`timescale 1ns/1ps

module udp_hdr_tx import ip_proto_pkg::*, frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  udp_hdr_t     udp_hdr,
    input  logic         udp_hdr_valid,
    output logic         udp_hdr_ready,
    input  stream_beat_t udp_beat,
    input  logic         udp_beat_valid,
    output logic         udp_beat_ready,
    output ip_hdr_t      ip_hdr,
    output logic         ip_hdr_valid,
    input  logic         ip_hdr_ready,
    output stream_beat_t ip_beat,
    output logic         ip_beat_valid,
    input  logic         ip_beat_ready
);

    typedef enum logic [1:0] {idle, hdr_out, write_hdr, payload} tx_state_t;

    tx_state_t  state;
    udp_hdr_t   hdr_q;
    logic [2:0] cnt;
    logic       pend;
    logic       udp_hdr_fire;
    logic       last_fire;

    // Header register is free again once the payload is flowing
    assign udp_hdr_ready  = (state == idle) || ((state == payload) && !pend);
    assign udp_hdr_fire   = udp_hdr_valid && udp_hdr_ready;
    assign udp_beat_ready = (state == payload) && ip_beat_ready;
    assign last_fire      = (state == payload) && udp_beat_valid && ip_beat_ready &&
                            udp_beat.last;

    always_comb begin
        ip_hdr.dscp      = hdr_q.dscp;
        ip_hdr.ecn       = hdr_q.ecn;
        ip_hdr.length    = hdr_q.length + IP_HDR_BYTES;
        ip_hdr.ttl       = hdr_q.ttl;
        ip_hdr.protocol  = PROTO_UDP;
        ip_hdr.source_ip = hdr_q.source_ip;
        ip_hdr.dest_ip   = hdr_q.dest_ip;
    end

    assign ip_hdr_valid = (state == hdr_out);

    always_comb begin
        ip_beat       = udp_beat;
        ip_beat_valid = 1'b0;
        case (state)
            write_hdr: begin
                ip_beat.data  = hdr_q[63 - 8 * cnt -: 8];
                ip_beat.last  = 1'b0;
                ip_beat.user  = 1'b0;
                ip_beat_valid = 1'b1;
            end
            payload: begin
                ip_beat_valid = udp_beat_valid;
            end
            default: begin
                ip_beat_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (udp_hdr_fire) begin
            hdr_q <= udp_hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= '0;
            pend  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (udp_hdr_valid) begin
                        state <= hdr_out;
                    end
                end
                hdr_out: begin
                    cnt <= '0;
                    if (ip_hdr_ready) begin
                        state <= write_hdr;
                    end
                end
                write_hdr: begin
                    if (ip_beat_ready) begin
                        cnt <= cnt + 3'd1;
                        if (cnt == 3'(UDP_HDR_BYTES - 1)) begin
                            state <= payload;
                        end
                    end
                end
                payload: begin
                    if (udp_hdr_fire) begin
                        pend <= 1'b1;
                    end
                    if (last_fire) begin
                        pend  <= 1'b0;
                        state <= (pend || udp_hdr_fire) ? hdr_out : idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* udp_hdr_rx.sv */
// UDP receive parser, strips the 8-byte UDP header off an IP payload
`timescale 1ns/1ps

module udp_hdr_rx import ip_proto_pkg::*, frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  ip_hdr_t      ip_hdr,
    input  logic         ip_hdr_valid,
    output logic         ip_hdr_ready,
    input  stream_beat_t ip_beat,
    input  logic         ip_beat_valid,
    output logic         ip_beat_ready,
    output udp_hdr_t     udp_hdr,
    output logic         udp_hdr_valid,
    input  logic         udp_hdr_ready,
    output stream_beat_t udp_beat,
    output logic         udp_beat_valid,
    input  logic         udp_beat_ready,
    output logic         error_hdr_early
);

    typedef enum logic [1:0] {idle, read_hdr, hdr_out, payload} rx_state_t;

    rx_state_t  state;
    udp_hdr_t   hdr_q;
    logic [2:0] cnt;
    logic       err_q;
    logic       hdr_beat_fire;

    assign ip_hdr_ready    = (state == idle);
    assign ip_beat_ready   = (state == read_hdr) || ((state == payload) && udp_beat_ready);
    assign udp_hdr         = hdr_q;
    assign udp_hdr_valid   = (state == hdr_out);
    assign udp_beat        = ip_beat;
    assign udp_beat_valid  = (state == payload) && ip_beat_valid;
    assign error_hdr_early = err_q;

    assign hdr_beat_fire = (state == read_hdr) && ip_beat_valid;

    always_ff @(posedge clk) begin
        if (ip_hdr_valid && ip_hdr_ready) begin
            hdr_q.dscp      <= ip_hdr.dscp;
            hdr_q.ecn       <= ip_hdr.ecn;
            hdr_q.ttl       <= ip_hdr.ttl;
            hdr_q.source_ip <= ip_hdr.source_ip;
            hdr_q.dest_ip   <= ip_hdr.dest_ip;
        end
        // Shift in ports, length, checksum; MSB first
        if (hdr_beat_fire) begin
            hdr_q[63:0] <= {hdr_q[55:0], ip_beat.data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= '0;
            err_q <= 1'b0;
        end else begin
            err_q <= 1'b0;
            case (state)
                idle: begin
                    cnt <= '0;
                    if (ip_hdr_valid) begin
                        state <= read_hdr;
                    end
                end
                read_hdr: begin
                    if (hdr_beat_fire) begin
                        cnt <= cnt + 3'd1;
                        if (ip_beat.last) begin
                            // Frame too short for a UDP header
                            state <= idle;
                            err_q <= 1'b1;
                        end else if (cnt == 3'(UDP_HDR_BYTES - 1)) begin
                            state <= hdr_out;
                        end
                    end
                end
                hdr_out: begin
                    if (udp_hdr_ready) begin
                        state <= payload;
                    end
                end
                payload: begin
                    if (ip_beat_valid && udp_beat_ready && ip_beat.last) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* ip_proto_demux.sv */
// IP protocol demux, steers received frames to the UDP parser or the IP output
`timescale 1ns/1ps

module ip_proto_demux import ip_proto_pkg::*, frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  ip_hdr_t      in_hdr,
    input  logic         in_hdr_valid,
    output logic         in_hdr_ready,
    input  stream_beat_t in_beat,
    input  logic         in_beat_valid,
    output logic         in_beat_ready,
    output ip_hdr_t      udp_hdr,
    output logic         udp_hdr_valid,
    input  logic         udp_hdr_ready,
    output stream_beat_t udp_beat,
    output logic         udp_beat_valid,
    input  logic         udp_beat_ready,
    output ip_hdr_t      ip_hdr,
    output logic         ip_hdr_valid,
    input  logic         ip_hdr_ready,
    output stream_beat_t ip_beat,
    output logic         ip_beat_valid,
    input  logic         ip_beat_ready
);

    typedef enum logic [1:0] {idle, route_udp, route_ip} route_t;

    route_t state;
    logic   is_udp;

    assign is_udp = (in_hdr.protocol == PROTO_UDP);

    // Header routing follows the protocol field while idle
    assign udp_hdr       = in_hdr;
    assign ip_hdr        = in_hdr;
    assign udp_hdr_valid = (state == idle) && in_hdr_valid && is_udp;
    assign ip_hdr_valid  = (state == idle) && in_hdr_valid && !is_udp;
    assign in_hdr_ready  = (state == idle) && (is_udp ? udp_hdr_ready : ip_hdr_ready);

    // Payload follows the registered route
    assign udp_beat       = in_beat;
    assign ip_beat        = in_beat;
    assign udp_beat_valid = (state == route_udp) && in_beat_valid;
    assign ip_beat_valid  = (state == route_ip) && in_beat_valid;
    assign in_beat_ready  = ((state == route_udp) && udp_beat_ready) ||
                            ((state == route_ip) && ip_beat_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (in_hdr_valid && in_hdr_ready) begin
                        state <= is_udp ? route_udp : route_ip;
                    end
                end
                default: begin
                    if (in_beat_valid && in_beat_ready && in_beat.last) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

endmodule

/* frame_pkg.sv */
// Frame package with IP header, UDP header and stream beat structs
package frame_pkg;

    import ip_proto_pkg::*;

    typedef struct packed {
        dscp_t    dscp;
        ecn_t     ecn;
        len16_t   length;
        ttl_t     ttl;
        proto_t   protocol;
        ip_addr_t source_ip;
        ip_addr_t dest_ip;
    } ip_hdr_t;

    // Port, length and checksum sit in the low 64 bits
    typedef struct packed {
        dscp_t    dscp;
        ecn_t     ecn;
        ttl_t     ttl;
        ip_addr_t source_ip;
        ip_addr_t dest_ip;
        port_t    source_port;
        port_t    dest_port;
        len16_t   length;
        len16_t   checksum;
    } udp_hdr_t;

    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

endpackage

/* ip_proto_pkg.sv */
// IP protocol package with field types and protocol constants
package ip_proto_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len16_t;
    typedef logic [7:0]  proto_t;
    typedef logic [5:0]  dscp_t;
    typedef logic [1:0]  ecn_t;
    typedef logic [7:0]  ttl_t;

    // Protocol number carried in the IP header
    localparam proto_t PROTO_UDP = 8'd17;

    // Header sizes, no IP options
    localparam len16_t IP_HDR_BYTES  = 16'd20;
    localparam int     UDP_HDR_BYTES = 8;

endpackage
